/* filelist.f */
hdl/gat_cfg_pkg.sv
hdl/gat_bus_pkg.sv
hdl/wh_buffer.sv
hdl/alpha_fifo.sv
hdl/feature_aggregator.sv
hdl/feature_mem_arbiter.sv
hdl/gat_aggr_top.sv
bench/gat_aggr_sva.sv
bench/gat_aggr_tb.sv

/* Bender.yml */
package:
  name: gat_aggr

dependencies: {}

sources:
  # Packages first, then RTL bottom up
  - hdl/gat_cfg_pkg.sv
  - hdl/gat_bus_pkg.sv
  - hdl/wh_buffer.sv
  - hdl/alpha_fifo.sv
  - hdl/feature_aggregator.sv
  - hdl/feature_mem_arbiter.sv
  - hdl/gat_aggr_top.sv

  # Testbench and bound assertions
  - target: test
    files:
      - bench/gat_aggr_sva.sv
      - bench/gat_aggr_tb.sv

/* bench/gat_aggr_tb.sv */
`default_nettype none

module gat_aggr_tb
  import gat_cfg_pkg::*;
  import gat_bus_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD  = 20;
  localparam int RUN_GROUPS  = 12;
  localparam int SEQ_GROUPS  = 10;
  localparam int HOLD_GROUPS = 4;
  localparam int HOLD_SIZE   = 12;
  localparam int MAX_COEFS   = 3 + 2 + (RUN_GROUPS + SEQ_GROUPS) * MAX_NODES
                               + HOLD_GROUPS * HOLD_SIZE;
  localparam int WD_CYCLES   = 200 * MAX_COEFS + 2000;
  localparam int WORD_W      = $bits(feat_word_t);

  // One host read waiting for comparison
  typedef struct packed {
    feat_addr_t addr;
    feat_word_t actual;
    feat_word_t expected;
    feat_word_t alt;
  } rd_check_t;

  logic                 clk;
  logic                 rst_n;
  wh_wr_t               wh_wr;
  logic                 alpha_push;
  alpha_t               alpha_in;
  logic                 alpha_full;
  mem_req_t             host_req;
  mem_rsp_t             host_rsp;
  logic [GRP_CNT_W-1:0] groups_written;

  wh_val_t    stage_wh [MAX_NODES][NUM_FEAT];
  alpha_t     stage_alpha [MAX_NODES];
  feat_word_t exp_mem [FEAT_DEPTH];
  feat_word_t old_mem [FEAT_DEPTH];
  rd_check_t  check_q [$];
  int         coef_cnt;
  int         grp_cnt;
  logic       saw_full;
  logic       run_done;

  gat_aggr_top dut_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .wh_wr          (wh_wr),
    .alpha_push     (alpha_push),
    .alpha_in       (alpha_in),
    .alpha_full     (alpha_full),
    .host_req       (host_req),
    .host_rsp       (host_rsp),
    .groups_written (groups_written)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1, "Run stopped at the first error");
  endtask

  function automatic string mismatch(input string sig, input logic [WORD_W-1:0] exp_v,
                                     input logic [WORD_W-1:0] act_v);
    return $sformatf("CHECK FAILED time=%0t signal=%s expected=%0h actual=%0h",
                     $time, sig, exp_v, act_v);
  endfunction

  initial begin
    repeat (WD_CYCLES) @(posedge clk);
    stop_run($sformatf("Timeout, the run did not end within %0d clock cycles", WD_CYCLES));
  end

  // ================================================
  // Reference model
  // ================================================
  // Floor-shifted products, 24-bit sum, then ReLU
  function automatic feat_word_t ref_feature(input int n);
    feat_word_t word;
    int         sum;
    int         prod;
    acc_t       acc;
    for (int f = 0; f < NUM_FEAT; f++) begin
      sum = 0;
      for (int k = 0; k < n; k++) begin
        prod = int'(stage_wh[k][f]) * int'(stage_alpha[k]);
        sum  = sum + (prod >>> ALPHA_FRAC);
      end
      acc          = acc_t'(sum);
      word.vals[f] = acc[ACC_W-1] ? feat_val_t'(0) : feat_val_t'(acc);
    end
    return word;
  endfunction

  function automatic void queue_check(input feat_addr_t addr, input feat_word_t actual,
                                      input feat_word_t expected, input feat_word_t alt);
    rd_check_t c;
    c.addr     = addr;
    c.actual   = actual;
    c.expected = expected;
    c.alt      = alt;
    check_q.push_back(c);
  endfunction

  initial begin
    rd_check_t c;
    forever begin
      @(posedge clk);
      while (check_q.size() > 0) begin
        c = check_q.pop_front();
        assert (c.actual === c.expected || c.actual === c.alt)
          else stop_run(mismatch($sformatf("host_rsp.rdata[%0d]", c.addr),
                                 c.expected, c.actual));
      end
    end
  end

  // ================================================
  // Host side tasks
  // ================================================
  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic host_access(input logic wr, input feat_addr_t addr, input feat_word_t wdata,
                             output feat_word_t rdata);
    host_req.req   = 1'b1;
    host_req.write = wr;
    host_req.addr  = addr;
    host_req.data  = wdata;
    do begin
      next_cycle();
    end while (!host_rsp.ack);
    rdata        = host_rsp.rdata;
    host_req.req = 1'b0;
    do begin
      next_cycle();
    end while (host_rsp.ack);
  endtask

  task automatic push_coef(input alpha_t a);
    alpha_push = 1'b1;
    alpha_in   = a;
    // Dropped while full, so keep offering it
    while (alpha_full) begin
      saw_full = 1'b1;
      next_cycle();
    end
    next_cycle();
    alpha_push = 1'b0;
  endtask

  task automatic random_group(input int n);
    for (int k = 0; k < n; k++) begin
      stage_alpha[k] = alpha_t'($urandom);
      for (int f = 0; f < NUM_FEAT; f++) begin
        stage_wh[k][f] = wh_val_t'($urandom);
      end
    end
  endtask

  // Wh entries first, then the coefficients that consume them
  task automatic send_group(input int n);
    wh_entry_t  e;
    feat_addr_t a;
    for (int k = 0; k < n; k++) begin
      for (int f = 0; f < NUM_FEAT; f++) begin
        e.vals[f] = stage_wh[k][f];
      end
      e.start = (k == 0);
      e.count = (k == 0) ? node_cnt_t'(n) : '0;
      wh_wr.valid = 1'b1;
      wh_wr.addr  = wh_addr_t'(coef_cnt + k);
      wh_wr.entry = e;
      next_cycle();
      wh_wr.valid = 1'b0;
    end
    a          = feat_addr_t'(grp_cnt);
    exp_mem[a] = ref_feature(n);
    for (int k = 0; k < n; k++) begin
      push_coef(stage_alpha[k]);
    end
    coef_cnt = coef_cnt + n;
    grp_cnt  = grp_cnt + 1;
  endtask

  task automatic wait_groups(input int target);
    while (groups_written != GRP_CNT_W'(target)) begin
      next_cycle();
    end
  endtask

  task automatic check_all();
    feat_word_t rd;
    for (int a = 0; a < FEAT_DEPTH; a++) begin
      host_access(1'b0, feat_addr_t'(a), '0, rd);
      queue_check(feat_addr_t'(a), rd, exp_mem[a], exp_mem[a]);
    end
  endtask

  task automatic random_reads();
    feat_word_t rd;
    feat_addr_t a;
    while (!run_done) begin
      a = feat_addr_t'($urandom);
      host_access(1'b0, a, '0, rd);
      queue_check(a, rd, old_mem[a], exp_mem[a]);
      repeat ($urandom % 4) next_cycle();
    end
  endtask

  // ================================================
  // Test sequence
  // ================================================
  initial begin
    feat_word_t rd;
    feat_word_t fill;
    feat_addr_t a;
    int         waited;
    void'($urandom(32'ha8d));
    rst_n      = 1'b0;
    wh_wr      = '0;
    alpha_push = 1'b0;
    alpha_in   = '0;
    host_req   = '0;
    coef_cnt   = 0;
    grp_cnt    = 0;
    saw_full   = 1'b0;
    run_done   = 1'b0;
    repeat (2) @(posedge clk);
    #2 rst_n = 1'b1;

    // Idle state after reset, then a known fill of the feature memory
    assert (groups_written == '0) else stop_run(mismatch("groups_written", '0, groups_written));
    assert (!alpha_full) else stop_run(mismatch("alpha_full", '0, alpha_full));
    for (int i = 0; i < FEAT_DEPTH; i++) begin
      for (int f = 0; f < NUM_FEAT; f++) begin
        fill.vals[f] = feat_val_t'(i * 24'h010101 + f);
      end
      host_access(1'b1, feat_addr_t'(i), fill, rd);
      exp_mem[i] = fill;
    end
    repeat (3) begin
      a = feat_addr_t'($urandom);
      host_access(1'b0, a, '0, rd);
      queue_check(a, rd, exp_mem[a], exp_mem[a]);
    end

    // Single group of three
    random_group(3);
    send_group(3);
    wait_groups(grp_cnt);
    host_access(1'b0, 4'd0, '0, rd);
    queue_check(4'd0, rd, exp_mem[0], exp_mem[0]);

    // Even features sum negative, odd ones positive
    for (int k = 0; k < 2; k++) begin
      stage_alpha[k] = (k == 0) ? 16'h4000 : 16'h6000;
      for (int f = 0; f < NUM_FEAT; f++) begin
        stage_wh[k][f] = (f % 2 == 0) ? wh_val_t'(-(100 * (f + 1) + k))
                                      : wh_val_t'(50 * (f + 1) + k);
      end
    end
    send_group(2);
    wait_groups(grp_cnt);
    host_access(1'b0, 4'd1, '0, rd);
    queue_check(4'd1, rd, exp_mem[1], exp_mem[1]);
    for (int f = 0; f < NUM_FEAT; f++) begin
      assert ((rd.vals[f] == '0) == (f % 2 == 0))
        else stop_run(mismatch($sformatf("host_rsp.rdata.vals[%0d]", f),
                               exp_mem[1].vals[f], rd.vals[f]));
    end

    // Host reads race the aggregator writes
    old_mem = exp_mem;
    fork
      begin
        for (int g = 0; g < RUN_GROUPS; g++) begin
          waited = 1 + ($urandom % MAX_NODES);
          random_group(waited);
          send_group(waited);
        end
        wait_groups(grp_cnt);
        run_done = 1'b1;
      end
      random_reads();
    join
    check_all();

    // Back to back groups, group index passes 16 and wraps
    for (int g = 0; g < SEQ_GROUPS; g++) begin
      waited = 1 + ($urandom % MAX_NODES);
      random_group(waited);
      send_group(waited);
    end
    wait_groups(grp_cnt);
    check_all();

    // Host parks on the feature port until the FIFO backs up
    saw_full       = 1'b0;
    host_req.req   = 1'b1;
    host_req.write = 1'b0;
    host_req.addr  = '0;
    do begin
      next_cycle();
    end while (!host_rsp.ack);
    fork
      begin
        for (int g = 0; g < HOLD_GROUPS; g++) begin
          random_group(HOLD_SIZE);
          send_group(HOLD_SIZE);
        end
      end
      begin
        waited = 0;
        while (!saw_full && waited < 500) begin
          next_cycle();
          waited = waited + 1;
        end
        repeat (4) next_cycle();
        host_req.req = 1'b0;
        do begin
          next_cycle();
        end while (host_rsp.ack);
      end
    join
    assert (saw_full) else stop_run("alpha_full never rose while the host held the port");
    wait_groups(grp_cnt);
    check_all();

    repeat (2) @(posedge clk);
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* bench/gat_aggr_sva.sv */
`default_nettype none

module gat_aggr_sva (
  input logic clk,
  input logic rst_n,
  input logic a_req,
  input logic a_ack,
  input logic b_req,
  input logic b_ack,
  input logic full,
  input logic empty
);

  timeunit 1ns;
  timeprecision 100ps;

  // ================================================
  // Arbiter handshake
  // ================================================
  one_ack: assert property (@(posedge clk) disable iff (!rst_n) !(a_ack && b_ack))
    else $error("ack high on both feature memory ports");

  a_ack_rise: assert property (@(posedge clk) disable iff (!rst_n) $rose(a_ack) |-> $past(a_req))
    else $error("port a ack rose without a request");

  b_ack_rise: assert property (@(posedge clk) disable iff (!rst_n) $rose(b_ack) |-> $past(b_req))
    else $error("port b ack rose without a request");

  // A request may only fall once its ack is up
  a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
    a_req && !a_ack |=> a_req || a_ack)
    else $error("port a request dropped before ack");

  b_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
    b_req && !b_ack |=> b_req || b_ack)
    else $error("port b request dropped before ack");

  // ================================================
  // FIFO flags
  // ================================================
  fifo_flags: assert property (@(posedge clk) disable iff (!rst_n) !(full && empty))
    else $error("coefficient FIFO full and empty at once");

endmodule

// Arbiter ports and FIFO flags all meet at the top
bind gat_aggr_top gat_aggr_sva sva_i (
  .clk   (clk),
  .rst_n (rst_n),
  .a_req (aggr_req.req),
  .a_ack (aggr_rsp.ack),
  .b_req (host_req.req),
  .b_ack (host_rsp.ack),
  .full  (alpha_full),
  .empty (alpha_empty)
);

`default_nettype wire

/* hdl/gat_aggr_top.sv */
`default_nettype none

module gat_aggr_top
  import gat_cfg_pkg::*;
  import gat_bus_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  wh_wr_t               wh_wr,
  input  logic                 alpha_push,
  input  alpha_t               alpha_in,
  output logic                 alpha_full,
  input  mem_req_t             host_req,
  output mem_rsp_t             host_rsp,
  output logic [GRP_CNT_W-1:0] groups_written
);

  wh_addr_t  wh_rd_addr;
  wh_entry_t wh_rd_data;
  alpha_t    alpha_dout;
  logic      alpha_empty;
  logic      alpha_pop;
  mem_req_t  aggr_req;
  mem_rsp_t  aggr_rsp;

  wh_buffer u_wh_buffer (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr      (wh_wr),
    .rd_addr (wh_rd_addr),
    .rd_data (wh_rd_data)
  );

  alpha_fifo u_alpha_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .push  (alpha_push),
    .din   (alpha_in),
    .full  (alpha_full),
    .pop   (alpha_pop),
    .dout  (alpha_dout),
    .empty (alpha_empty)
  );

  feature_aggregator u_aggr (
    .clk            (clk),
    .rst_n          (rst_n),
    .alpha_empty    (alpha_empty),
    .alpha_pop      (alpha_pop),
    .alpha          (alpha_dout),
    .wh_addr        (wh_rd_addr),
    .wh_data        (wh_rd_data),
    .mem_req        (aggr_req),
    .mem_rsp        (aggr_rsp),
    .groups_written (groups_written)
  );

  // Aggregator on port a, host on port b
  feature_mem_arbiter u_arbiter (
    .clk   (clk),
    .rst_n (rst_n),
    .a_req (aggr_req),
    .a_rsp (aggr_rsp),
    .b_req (host_req),
    .b_rsp (host_rsp)
  );

endmodule

`default_nettype wire

/* hdl/feature_mem_arbiter.sv */
`default_nettype none

module feature_mem_arbiter
  import gat_cfg_pkg::*;
  import gat_bus_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  mem_req_t a_req,
  output mem_rsp_t a_rsp,
  input  mem_req_t b_req,
  output mem_rsp_t b_rsp
);

  typedef enum logic [1:0] {
    IDLE,
    ACK_A,
    ACK_B
  } arb_state_e;

  arb_state_e state;
  logic       last_b;
  logic       grant_a;
  logic       grant_b;
  logic       a_ack;
  logic       b_ack;
  mem_req_t   sel;
  feat_word_t rdata_q;
  feat_word_t mem [FEAT_DEPTH];

  // ================================================
  // Round-robin grant, only with no open transaction
  // ================================================
  always_comb begin
    grant_a = (state == IDLE) && a_req.req && (!b_req.req || last_b);
    grant_b = (state == IDLE) && b_req.req && (!a_req.req || !last_b);
    sel     = grant_b ? b_req : a_req;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state  <= IDLE;
      last_b <= 1'b0;
      a_ack  <= 1'b0;
      b_ack  <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (grant_a) begin
            a_ack  <= 1'b1;
            last_b <= 1'b0;
            state  <= ACK_A;
          end else if (grant_b) begin
            b_ack  <= 1'b1;
            last_b <= 1'b1;
            state  <= ACK_B;
          end
        end
        ACK_A: begin
          if (!a_req.req) begin
            a_ack <= 1'b0;
            state <= IDLE;
          end
        end
        ACK_B: begin
          if (!b_req.req) begin
            b_ack <= 1'b0;
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Access happens on the edge that raises ack
  always_ff @(posedge clk) begin
    if (grant_a || grant_b) begin
      if (sel.write) begin
        mem[sel.addr] <= sel.data;
      end else begin
        rdata_q <= mem[sel.addr];
      end
    end
  end

  always_comb begin
    a_rsp.ack   = a_ack;
    a_rsp.rdata = rdata_q;
    b_rsp.ack   = b_ack;
    b_rsp.rdata = rdata_q;
  end

endmodule

`default_nettype wire

/* hdl/feature_aggregator.sv */
`default_nettype none

module feature_aggregator
  import gat_cfg_pkg::*;
  import gat_bus_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 alpha_empty,
  output logic                 alpha_pop,
  input  alpha_t               alpha,
  output wh_addr_t             wh_addr,
  input  wh_entry_t            wh_data,
  output mem_req_t             mem_req,
  input  mem_rsp_t             mem_rsp,
  output logic [GRP_CNT_W-1:0] groups_written
);

  typedef enum logic [1:0] {
    IDLE,
    REQ,
    WAIT_DROP
  } wr_state_e;

  wr_state_e            state;
  wh_addr_t             rd_ptr;
  logic                 freeze;
  logic                 req_q;
  feat_word_t           word_q;
  feat_word_t           relu_word;

  // Stage 1 sits beside the buffer read register
  logic                 s1_vld;
  alpha_t               s1_alpha;
  acc_t [NUM_FEAT-1:0]  prod;

  logic                 s2_vld;
  logic                 s2_start;
  node_cnt_t            s2_cnt;
  acc_t [NUM_FEAT-1:0]  s2_prod;

  acc_t [NUM_FEAT-1:0]  acc;
  acc_t [NUM_FEAT-1:0]  acc_next;
  node_cnt_t            rem;
  node_cnt_t            grp_len;
  logic                 s2_end;

  // ================================================
  // Pop control and pipeline stall
  // ================================================
  assign s2_end    = s2_vld && (grp_len == node_cnt_t'(1));
  // A group end cannot land on the word still being written
  assign freeze    = (state != IDLE) && s2_end;
  assign alpha_pop = !alpha_empty && !freeze;
  // While frozen, re-read the entry held in stage 1
  assign wh_addr   = freeze ? rd_ptr - wh_addr_t'(1) : rd_ptr;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr <= '0;
      s1_vld <= 1'b0;
      s2_vld <= 1'b0;
    end else begin
      if (alpha_pop) begin
        rd_ptr <= rd_ptr + wh_addr_t'(1);
      end
      if (!freeze) begin
        s1_vld <= alpha_pop;
        s2_vld <= s1_vld;
      end
    end
  end

  // ================================================
  // Datapath
  // ================================================
  // Product scaled back by the fraction bits, floor truncation
  always_comb begin
    logic signed [PROD_W-1:0] full_prod;
    for (int i = 0; i < NUM_FEAT; i++) begin
      full_prod = $signed(wh_data.vals[i]) * $signed({1'b0, s1_alpha});
      prod[i]   = acc_t'(full_prod >>> ALPHA_FRAC);
    end
  end

  always_comb begin
    grp_len = s2_start ? s2_cnt : rem;
    for (int i = 0; i < NUM_FEAT; i++) begin
      acc_next[i]       = s2_start ? s2_prod[i] : acc[i] + s2_prod[i];
      relu_word.vals[i] = acc_next[i][ACC_W-1] ? '0 : feat_val_t'(acc_next[i]);
    end
  end

  always_ff @(posedge clk) begin
    if (!freeze) begin
      s1_alpha <= alpha;
      s2_prod  <= prod;
      s2_start <= wh_data.start;
      s2_cnt   <= wh_data.count;
    end
    if (s2_vld && !freeze) begin
      acc <= acc_next;
    end
    if (state == IDLE && s2_end) begin
      word_q <= relu_word;
    end
  end

  // Neighbours left in the current group
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rem <= '0;
    end else if (s2_vld && !freeze) begin
      rem <= grp_len - node_cnt_t'(1);
    end
  end

  // ================================================
  // Four-phase write of the finished word
  // ================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state          <= IDLE;
      req_q          <= 1'b0;
      groups_written <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (s2_end) begin
            req_q <= 1'b1;
            state <= REQ;
          end
        end
        REQ: begin
          if (mem_rsp.ack) begin
            req_q <= 1'b0;
            state <= WAIT_DROP;
          end
        end
        WAIT_DROP: begin
          if (!mem_rsp.ack) begin
            groups_written <= groups_written + 1'b1;
            state          <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Group index is the low bits of the completed count
  always_comb begin
    mem_req.req   = req_q;
    mem_req.write = 1'b1;
    mem_req.addr  = feat_addr_t'(groups_written);
    mem_req.data  = word_q;
  end

endmodule

`default_nettype wire

/* hdl/alpha_fifo.sv */
`default_nettype none

module alpha_fifo
  import gat_cfg_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   push,
  input  alpha_t din,
  output logic   full,
  input  logic   pop,
  output alpha_t dout,
  output logic   empty
);

  logic [ALPHA_PTR_W-1:0] wr_ptr;
  logic [ALPHA_PTR_W-1:0] rd_ptr;
  logic [ALPHA_PTR_W:0]   count;
  logic                   do_push;
  logic                   do_pop;
  alpha_t                 mem [ALPHA_DEPTH];

  // Blocked requests are simply dropped
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  assign full  = (count == (ALPHA_PTR_W + 1)'(ALPHA_DEPTH));
  assign empty = (count == '0);
  assign dout  = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= din;
    end
  end

  // Pointers wrap on their own width
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hdl/wh_buffer.sv */
`default_nettype none

module wh_buffer
  import gat_cfg_pkg::*;
  import gat_bus_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  wh_wr_t    wr,
  input  wh_addr_t  rd_addr,
  output wh_entry_t rd_data
);

  wh_entry_t mem [WH_DEPTH];

  // Host write port
  always_ff @(posedge clk) begin
    if (wr.valid) begin
      mem[wr.addr] <= wr.entry;
    end
  end

  // Registered read, data one cycle after the address
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_data <= '0;
    end else begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

/* hdl/gat_bus_pkg.sv */
`default_nettype none

package gat_bus_pkg;
  import gat_cfg_pkg::*;

  // One projected neighbour vector plus group framing
  typedef struct packed {
    wh_val_t [NUM_FEAT-1:0] vals;
    node_cnt_t              count;
    logic                   start;
  } wh_entry_t;

  typedef struct packed {
    logic      valid;
    wh_addr_t  addr;
    wh_entry_t entry;
  } wh_wr_t;

  typedef struct packed {
    feat_val_t [NUM_FEAT-1:0] vals;
  } feat_word_t;

  // Four-phase feature memory port
  typedef struct packed {
    logic       req;
    logic       write;
    feat_addr_t addr;
    feat_word_t data;
  } mem_req_t;

  typedef struct packed {
    logic       ack;
    feat_word_t rdata;
  } mem_rsp_t;

endpackage

`default_nettype wire

/* hdl/gat_cfg_pkg.sv */
`default_nettype none

package gat_cfg_pkg;

  // ================================================
  // Sizes
  // ================================================
  localparam int NUM_FEAT    = 4;
  localparam int WH_DEPTH    = 64;
  localparam int WH_ADDR_W   = 6;
  localparam int ALPHA_DEPTH = 16;
  localparam int ALPHA_PTR_W = $clog2(ALPHA_DEPTH);
  localparam int FEAT_DEPTH  = 16;
  localparam int FEAT_ADDR_W = 4;
  localparam int MAX_NODES   = 15;
  localparam int NODE_CNT_W  = $clog2(MAX_NODES + 1);
  localparam int GRP_CNT_W   = 8;

  // Fixed point, coefficient is Q1.15
  localparam int WH_W       = 12;
  localparam int ALPHA_W    = 16;
  localparam int ALPHA_FRAC = 15;
  localparam int ACC_W      = 24;
  // Wh times zero-extended coefficient
  localparam int PROD_W     = WH_W + ALPHA_W + 1;

  typedef logic signed [WH_W-1:0]   wh_val_t;
  typedef logic [ALPHA_W-1:0]       alpha_t;
  typedef logic signed [ACC_W-1:0]  acc_t;
  typedef logic [ACC_W-1:0]         feat_val_t;
  typedef logic [NODE_CNT_W-1:0]    node_cnt_t;
  typedef logic [WH_ADDR_W-1:0]     wh_addr_t;
  typedef logic [FEAT_ADDR_W-1:0]   feat_addr_t;

endpackage

`default_nettype wire
